// File: hw/bg_defs.svh
// Line window, tile size and bus width defines shared by the renderer RTL and its testbench
`ifndef BG_DEFS_SVH
`define BG_DEFS_SVH

// Fetched pixel window, first and one-past-last position
// Both must be multiples of the tile edge
`define BG_H_START 48
`define BG_H_END 176

// Tile edge in pixels
`define BG_TILE_PX 16

// Memory channel widths
`define BG_ADDR_W 16
`define BG_DATA_W 16

// Display coordinate width
`define BG_X_W 10

// Scanline RAM address width, four pixels per word
`define BG_LINE_WORDS_W 8

`endif

// File: hw/bg_reg_pkg.sv
// CPU side register map opcodes and field types, referenced by scoped names
`include "bg_defs.svh"

package bg_reg_pkg;

	// Register addresses, anything above 9 is ignored
	typedef enum logic [3:0] {
		ctrl0     = 4'd0,
		scroll_x0 = 4'd1,
		scroll_y0 = 4'd2,
		map_addr0 = 4'd3,
		set_addr0 = 4'd4,
		ctrl1     = 4'd5,
		scroll_x1 = 4'd6,
		scroll_y1 = 4'd7,
		map_addr1 = 4'd8,
		set_addr1 = 4'd9
	} bg_reg_e;

	// Full register word as written by the CPU
	typedef logic [`BG_DATA_W-1:0] reg_data_t;

	// Upper nibble of a layer's color index
	typedef logic [3:0] pal_hi_t;

endpackage

// File: hw/bg_fetch_pkg.sv
// Render side types for the tile fetcher and the line buffer mixer, referenced by scoped names
`include "bg_defs.svh"

package bg_fetch_pkg;

	// Fetcher states, one pass per layer
	typedef enum logic [2:0] {
		idle,
		begin_layer,
		fetch_tile,
		wait_tile,
		fetch_data,
		wait_data
	} fetch_state_e;

	// Palette index sent to the display
	typedef logic [7:0] color_idx_t;

	// Memory and scanline word, four 4-bit pixels
	// Lowest nibble is the leftmost pixel
	typedef logic [`BG_DATA_W-1:0] mem_word_t;

endpackage

// File: hw/bg_regs.sv
// CPU-writable layer configuration registers, one field updated per write cycle
`timescale 1ns/10ps

module bg_regs (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  logic                  wr,
	input  bg_reg_pkg::bg_reg_e   address,
	input  bg_reg_pkg::reg_data_t data_in,
	output logic                  en0,
	output logic                  en1,
	output bg_reg_pkg::pal_hi_t   pal_hi0,
	output bg_reg_pkg::pal_hi_t   pal_hi1,
	output bg_reg_pkg::reg_data_t scroll_x0,
	output bg_reg_pkg::reg_data_t scroll_x1,
	output bg_reg_pkg::reg_data_t scroll_y0,
	output bg_reg_pkg::reg_data_t scroll_y1,
	output bg_reg_pkg::reg_data_t map_addr0,
	output bg_reg_pkg::reg_data_t map_addr1,
	output bg_reg_pkg::reg_data_t set_addr0,
	output bg_reg_pkg::reg_data_t set_addr1
);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			en0       <= 1'b0;
			en1       <= 1'b0;
			pal_hi0   <= '0;
			pal_hi1   <= '0;
			scroll_x0 <= '0;
			scroll_x1 <= '0;
			scroll_y0 <= '0;
			scroll_y1 <= '0;
			map_addr0 <= '0;
			map_addr1 <= '0;
			set_addr0 <= '0;
			set_addr1 <= '0;
		end else if (wr) begin
			case (address)
				// Control: bit 0 enable, bits 7:4 palette high nibble
				bg_reg_pkg::ctrl0: begin
					en0     <= data_in[0];
					pal_hi0 <= data_in[7:4];
				end
				bg_reg_pkg::scroll_x0: scroll_x0 <= data_in;
				bg_reg_pkg::scroll_y0: scroll_y0 <= data_in;
				bg_reg_pkg::map_addr0: map_addr0 <= data_in;
				bg_reg_pkg::set_addr0: set_addr0 <= data_in;
				bg_reg_pkg::ctrl1: begin
					en1     <= data_in[0];
					pal_hi1 <= data_in[7:4];
				end
				bg_reg_pkg::scroll_x1: scroll_x1 <= data_in;
				bg_reg_pkg::scroll_y1: scroll_y1 <= data_in;
				bg_reg_pkg::map_addr1: map_addr1 <= data_in;
				bg_reg_pkg::set_addr1: set_addr1 <= data_in;
				default: ;
			endcase
		end
	end

endmodule

// File: hw/scanline_bram.sv
// Simple dual-port block RAM with registered read, holds one scanline of packed pixels
`timescale 1ns/10ps

module scanline_bram #(
	parameter int DATA_W = 16,
	parameter int ADDR_W = 8
) (
	input  logic              CLK,
	input  logic [ADDR_W-1:0] rd_addr,
	output logic [DATA_W-1:0] rd_data,
	input  logic [ADDR_W-1:0] wr_addr,
	input  logic [DATA_W-1:0] wr_data,
	input  logic              wr
);

	logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];

	// Block RAM powers up cleared
	initial begin
		for (int i = 0; i < (1 << ADDR_W); i++)
			mem[i] = '0;
	end

	always_ff @(posedge CLK) begin
		if (wr)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

endmodule

// File: hw/tile_fetcher.sv
// Per-line fetch FSM that reads tile map bytes and pixel words from memory into the scanline store
`timescale 1ns/10ps
`include "bg_defs.svh"

module tile_fetcher (
	input  logic                          CLK,
	input  logic                          RSTb,
	input  logic                          h_tick,
	input  logic [`BG_X_W-1:0]            display_y,
	input  logic                          en0,
	input  logic                          en1,
	input  bg_reg_pkg::reg_data_t         scroll_x0,
	input  bg_reg_pkg::reg_data_t         scroll_x1,
	input  bg_reg_pkg::reg_data_t         scroll_y0,
	input  bg_reg_pkg::reg_data_t         scroll_y1,
	input  bg_reg_pkg::reg_data_t         map_addr0,
	input  bg_reg_pkg::reg_data_t         map_addr1,
	input  bg_reg_pkg::reg_data_t         set_addr0,
	input  bg_reg_pkg::reg_data_t         set_addr1,
	output logic [`BG_ADDR_W-1:0]         mem_address,
	input  bg_fetch_pkg::mem_word_t       mem_data,
	output logic                          mem_rvalid,
	input  logic                          mem_rready,
	output logic                          line_start,
	output logic                          buf_wr,
	output logic                          buf_layer,
	output logic [`BG_LINE_WORDS_W-1:0]   buf_addr,
	output bg_fetch_pkg::mem_word_t       buf_data
);

	localparam int AW = `BG_ADDR_W;
	localparam int XW = `BG_X_W;
	localparam int LW = `BG_LINE_WORDS_W;
	// Byte index into the tile map needs one bit more than a word address
	localparam int IW = `BG_ADDR_W + 1;
	localparam logic [XW-1:0] H_START = XW'(`BG_H_START);
	localparam logic [XW-1:0] H_END   = XW'(`BG_H_END);
	localparam logic [XW-1:0] TILE_PX = XW'(`BG_TILE_PX);

	bg_fetch_pkg::fetch_state_e state;
	logic                       layer;
	logic [XW-1:0]              y_line;
	logic [XW-1:0]              pos;
	logic [IW-1:0]              tile_index;
	logic [7:0]                 tile;
	logic [1:0]                 word_k;

	bg_reg_pkg::reg_data_t      cur_scroll_x;
	bg_reg_pkg::reg_data_t      cur_scroll_y;
	bg_reg_pkg::reg_data_t      cur_map_addr;
	bg_reg_pkg::reg_data_t      cur_set_addr;
	bg_reg_pkg::reg_data_t      map_y;
	logic [IW-1:0]              first_index;
	logic [AW-1:0]              data_addr;
	logic [7:0]                 tile_byte;

	// Configuration of the layer being fetched
	assign cur_scroll_x = layer ? scroll_x1 : scroll_x0;
	assign cur_scroll_y = layer ? scroll_y1 : scroll_y0;
	assign cur_map_addr = layer ? map_addr1 : map_addr0;
	assign cur_set_addr = layer ? set_addr1 : set_addr0;

	// Map row from bits 10:4 and fine row from bits 3:0
	assign map_y = cur_scroll_y + bg_reg_pkg::reg_data_t'(y_line);

	// Map rows are 128 tiles wide
	assign first_index = {cur_map_addr, 1'b0} + IW'({map_y[10:4], 7'b0}) +
		IW'(cur_scroll_x[10:4]);

	// Each 1024-word band holds 16 tiles with 64 words per fine row
	assign data_addr = cur_set_addr + AW'({tile[7:4], 10'b0}) + AW'({tile[3:0], 2'b0}) +
		AW'({map_y[3:0], 6'b0}) + AW'(word_k);

	assign tile_byte = tile_index[0] ? mem_data[15:8] : mem_data[7:0];

	assign line_start = h_tick & en0;

	always_ff @(posedge CLK) begin
		buf_wr <= 1'b0;
		if (line_start) begin
			state      <= bg_fetch_pkg::begin_layer;
			layer      <= 1'b0;
			mem_rvalid <= 1'b0;
			y_line     <= display_y;
		end else begin
			case (state)
				bg_fetch_pkg::begin_layer: begin
					tile_index <= first_index;
					pos        <= H_START;
					state      <= bg_fetch_pkg::fetch_tile;
				end
				bg_fetch_pkg::fetch_tile: begin
					if (pos == H_END) begin
						if (!layer && en1) begin
							layer <= 1'b1;
							state <= bg_fetch_pkg::begin_layer;
						end else begin
							state <= bg_fetch_pkg::idle;
						end
					end else begin
						mem_address <= tile_index[IW-1:1];
						mem_rvalid  <= 1'b1;
						state       <= bg_fetch_pkg::wait_tile;
					end
				end
				bg_fetch_pkg::wait_tile: begin
					if (mem_rready) begin
						mem_rvalid <= 1'b0;
						// Transparent tile 255 leaves its pixels cleared
						if (tile_byte == 8'hff) begin
							pos        <= pos + TILE_PX;
							tile_index <= tile_index + 1'b1;
							state      <= bg_fetch_pkg::fetch_tile;
						end else begin
							tile   <= tile_byte;
							word_k <= 2'd0;
							state  <= bg_fetch_pkg::fetch_data;
						end
					end
				end
				bg_fetch_pkg::fetch_data: begin
					mem_address <= data_addr;
					mem_rvalid  <= 1'b1;
					state       <= bg_fetch_pkg::wait_data;
				end
				bg_fetch_pkg::wait_data: begin
					if (mem_rready) begin
						mem_rvalid <= 1'b0;
						buf_wr     <= 1'b1;
						buf_layer  <= layer;
						buf_addr   <= pos[XW-1:2] + LW'(word_k);
						buf_data   <= mem_data;
						if (word_k == 2'd3) begin
							pos        <= pos + TILE_PX;
							tile_index <= tile_index + 1'b1;
							state      <= bg_fetch_pkg::fetch_tile;
						end else begin
							word_k <= word_k + 2'd1;
							state  <= bg_fetch_pkg::fetch_data;
						end
					end
				end
				default: state <= bg_fetch_pkg::idle;
			endcase
		end
		// Back to idle with no request pending
		if (!RSTb) begin
			state      <= bg_fetch_pkg::idle;
			layer      <= 1'b0;
			mem_rvalid <= 1'b0;
			buf_wr     <= 1'b0;
		end
	end

endmodule

// File: hw/line_buffer_mixer.sv
// Double-buffered scanline store for two layers with clear-after-read and layer priority
`timescale 1ns/10ps
`include "bg_defs.svh"

module line_buffer_mixer (
	input  logic                        CLK,
	input  logic                        RSTb,
	input  logic                        line_start,
	input  logic                        buf_wr,
	input  logic                        buf_layer,
	input  logic [`BG_LINE_WORDS_W-1:0] buf_addr,
	input  bg_fetch_pkg::mem_word_t     buf_data,
	input  logic [`BG_X_W-1:0]          display_x,
	input  logic                        re,
	input  bg_reg_pkg::reg_data_t       scroll_x0,
	input  bg_reg_pkg::reg_data_t       scroll_x1,
	input  bg_reg_pkg::pal_hi_t         pal_hi0,
	input  bg_reg_pkg::pal_hi_t         pal_hi1,
	output bg_fetch_pkg::color_idx_t    color_index
);

	localparam int XW = `BG_X_W;
	localparam int LW = `BG_LINE_WORDS_W;

	// RAM index is {layer, buffer}, fill_buf selects the pair being written
	logic                    fill_buf;
	logic                    disp_q;
	logic                    re_q;
	logic [XW-1:0]           rd_x0;
	logic [XW-1:0]           rd_x1;
	logic [LW-1:0]           rd_word [2];
	logic [1:0]              sel_q [2];
	logic [LW-1:0]           ram_rd_addr [4];
	logic [LW-1:0]           ram_wr_addr [4];
	bg_fetch_pkg::mem_word_t ram_wr_data [4];
	bg_fetch_pkg::mem_word_t ram_rd_data [4];
	logic                    ram_wr [4];
	logic [3:0]              nib0;
	logic [3:0]              nib1;

	function automatic logic [3:0] pick_nibble(input bg_fetch_pkg::mem_word_t word,
		input logic [1:0] sel);
		return word[{sel, 2'b00} +: 4];
	endfunction

	for (genvar j = 0; j < 4; j++) begin : g_ram
		scanline_bram #(.DATA_W(`BG_DATA_W), .ADDR_W(LW)) u_ram (
			.CLK(CLK),
			.rd_addr(ram_rd_addr[j]),
			.rd_data(ram_rd_data[j]),
			.wr_addr(ram_wr_addr[j]),
			.wr_data(ram_wr_data[j]),
			.wr(ram_wr[j])
		);
	end

	// Fine scroll shifts each layer's read position
	assign rd_x0 = display_x + XW'(scroll_x0[3:0]);
	assign rd_x1 = display_x + XW'(scroll_x1[3:0]);
	assign rd_word[0] = rd_x0[XW-1:2];
	assign rd_word[1] = rd_x1[XW-1:2];

	// Fill pair takes fetcher writes, display pair clears the word behind the reader
	always_comb begin
		for (int j = 0; j < 4; j++) begin
			ram_rd_addr[j] = rd_word[j / 2];
			if (j[0] == fill_buf) begin
				ram_wr[j]      = buf_wr && (buf_layer == j[1]);
				ram_wr_addr[j] = buf_addr;
				ram_wr_data[j] = buf_data;
			end else begin
				ram_wr[j]      = re;
				ram_wr_addr[j] = rd_word[j / 2] - 1'b1;
				ram_wr_data[j] = '0;
			end
		end
	end

	assign nib0 = pick_nibble(ram_rd_data[{1'b0, disp_q}], sel_q[0]);
	assign nib1 = pick_nibble(ram_rd_data[{1'b1, disp_q}], sel_q[1]);

	// Pixel positions and buffer select follow the RAM read by one cycle
	always_ff @(posedge CLK) begin
		disp_q   <= ~fill_buf;
		sel_q[0] <= rd_x0[1:0];
		sel_q[1] <= rd_x1[1:0];
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			fill_buf    <= 1'b0;
			re_q        <= 1'b0;
			color_index <= '0;
		end else begin
			re_q <= re;
			if (line_start)
				fill_buf <= ~fill_buf;
			// Layer 2 shows through where layer 1 is zero
			if (re_q)
				color_index <= (nib0 != 4'd0) ? {pal_hi0, nib0} : {pal_hi1, nib1};
		end
	end

endmodule

// File: hw/bg_renderer.sv
// Two-layer tile background renderer top, joins the registers, the fetcher and the line mixer
`timescale 1ns/10ps
`include "bg_defs.svh"

module bg_renderer (
	input  logic                     CLK,
	input  logic                     RSTb,
	input  logic                     wr,
	input  bg_reg_pkg::bg_reg_e      address,
	input  bg_reg_pkg::reg_data_t    data_in,
	// Frame tick, kept for compatibility with the video timing
	input  logic                     v_tick,
	input  logic                     h_tick,
	input  logic [`BG_X_W-1:0]       display_x,
	input  logic [`BG_X_W-1:0]       display_y,
	input  logic                     re,
	output bg_fetch_pkg::color_idx_t color_index,
	output logic [`BG_ADDR_W-1:0]    mem_address,
	input  bg_fetch_pkg::mem_word_t  mem_data,
	output logic                     mem_rvalid,
	input  logic                     mem_rready
);

	logic                          en0;
	logic                          en1;
	bg_reg_pkg::pal_hi_t           pal_hi0;
	bg_reg_pkg::pal_hi_t           pal_hi1;
	bg_reg_pkg::reg_data_t         scroll_x0;
	bg_reg_pkg::reg_data_t         scroll_x1;
	bg_reg_pkg::reg_data_t         scroll_y0;
	bg_reg_pkg::reg_data_t         scroll_y1;
	bg_reg_pkg::reg_data_t         map_addr0;
	bg_reg_pkg::reg_data_t         map_addr1;
	bg_reg_pkg::reg_data_t         set_addr0;
	bg_reg_pkg::reg_data_t         set_addr1;
	logic                          line_start;
	logic                          buf_wr;
	logic                          buf_layer;
	logic [`BG_LINE_WORDS_W-1:0]   buf_addr;
	bg_fetch_pkg::mem_word_t       buf_data;

	bg_regs u_regs (
		.CLK(CLK), .RSTb(RSTb), .wr(wr), .address(address), .data_in(data_in),
		.en0(en0), .en1(en1), .pal_hi0(pal_hi0), .pal_hi1(pal_hi1),
		.scroll_x0(scroll_x0), .scroll_x1(scroll_x1),
		.scroll_y0(scroll_y0), .scroll_y1(scroll_y1),
		.map_addr0(map_addr0), .map_addr1(map_addr1),
		.set_addr0(set_addr0), .set_addr1(set_addr1)
	);

	tile_fetcher u_fetcher (
		.CLK(CLK), .RSTb(RSTb), .h_tick(h_tick), .display_y(display_y),
		.en0(en0), .en1(en1),
		.scroll_x0(scroll_x0), .scroll_x1(scroll_x1),
		.scroll_y0(scroll_y0), .scroll_y1(scroll_y1),
		.map_addr0(map_addr0), .map_addr1(map_addr1),
		.set_addr0(set_addr0), .set_addr1(set_addr1),
		.mem_address(mem_address), .mem_data(mem_data),
		.mem_rvalid(mem_rvalid), .mem_rready(mem_rready),
		.line_start(line_start), .buf_wr(buf_wr), .buf_layer(buf_layer),
		.buf_addr(buf_addr), .buf_data(buf_data)
	);

	line_buffer_mixer u_mixer (
		.CLK(CLK), .RSTb(RSTb), .line_start(line_start),
		.buf_wr(buf_wr), .buf_layer(buf_layer), .buf_addr(buf_addr), .buf_data(buf_data),
		.display_x(display_x), .re(re),
		.scroll_x0(scroll_x0), .scroll_x1(scroll_x1),
		.pal_hi0(pal_hi0), .pal_hi1(pal_hi1),
		.color_index(color_index)
	);

endmodule

// File: testbench/bg_renderer_properties.sv
// Concurrent checks on the memory channel and scanline writes, bound into the renderer top
`timescale 1ns/10ps
`include "bg_defs.svh"

module bg_renderer_properties (
	input logic                  CLK,
	input logic                  RSTb,
	input logic                  mem_rvalid,
	input logic                  mem_rready,
	input logic [`BG_ADDR_W-1:0] mem_address,
	input logic                  buf_wr,
	input logic                  line_start
);

	// Request held with a steady address until the memory answers
	a_addr_stable: assert property (@(posedge CLK) disable iff (!RSTb)
		(mem_rvalid && !mem_rready) |=> (mem_rvalid && $stable(mem_address)))
		else $error("mem_address or mem_rvalid changed before mem_rready");

	a_drop_after_ready: assert property (@(posedge CLK) disable iff (!RSTb)
		mem_rready |=> !mem_rvalid)
		else $error("mem_rvalid still high the cycle after mem_rready");

	a_reset_idle: assert property (@(posedge CLK) !RSTb |=> !mem_rvalid)
		else $error("mem_rvalid high during reset");

	// A swap during a write would send it into the pair going to the display
	a_write_to_fill: assert property (@(posedge CLK) disable iff (!RSTb)
		buf_wr |-> !line_start)
		else $error("buffer write hit the buffer pair being displayed");

endmodule

bind bg_renderer bg_renderer_properties u_properties (
	.CLK(CLK), .RSTb(RSTb), .mem_rvalid(mem_rvalid), .mem_rready(mem_rready),
	.mem_address(mem_address), .buf_wr(buf_wr), .line_start(line_start)
);

// File: testbench/tb_bg_renderer.sv
// Testbench that replays the line tests held in the vectors file against the tile background renderer
`timescale 1ns/10ps
`include "bg_defs.svh"

module tb_bg_renderer;

	localparam int VEC_WORDS    = 512;
	localparam int RESET_CYCLES = 10;
	// Worst case for two layers of eight opaque tiles at four cycles latency
	localparam int FETCH_BUDGET = 600;
	localparam int LINE_PX      = `BG_H_END - `BG_H_START;
	// Reading one word past the window clears the last buffer word
	localparam int SWEEP_EXTRA  = 4;

	logic                     CLK;
	logic                     RSTb;
	logic                     wr;
	bg_reg_pkg::bg_reg_e      address;
	bg_reg_pkg::reg_data_t    data_in;
	logic                     v_tick;
	logic                     h_tick;
	logic [`BG_X_W-1:0]       display_x;
	logic [`BG_X_W-1:0]       display_y;
	logic                     re;
	bg_fetch_pkg::color_idx_t color_index;
	logic [`BG_ADDR_W-1:0]    mem_address;
	bg_fetch_pkg::mem_word_t  mem_data;
	logic                     mem_rvalid;
	logic                     mem_rready;

	logic [15:0]              vec [0:VEC_WORDS-1];
	logic [15:0]              mem_img [0:65535];
	bg_fetch_pkg::color_idx_t exp_px [0:LINE_PX-1];
	logic [31:0]              lfsr;
	logic                     busy;
	int                       wait_left;
	int                       vp;
	int                       read_count;
	int                       cycles = 0;
	int                       cycle_limit = 0;

	bg_renderer u_dut (
		.CLK(CLK), .RSTb(RSTb), .wr(wr), .address(address), .data_in(data_in),
		.v_tick(v_tick), .h_tick(h_tick), .display_x(display_x), .display_y(display_y),
		.re(re), .color_index(color_index), .mem_address(mem_address),
		.mem_data(mem_data), .mem_rvalid(mem_rvalid), .mem_rready(mem_rready)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic logic [15:0] pop_vector();
		logic [15:0] word;
		word = vec[vp];
		vp++;
		return word;
	endfunction

	task automatic stop_on_failure();
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_color(input string name, input bg_fetch_pkg::color_idx_t expected,
		input bg_fetch_pkg::color_idx_t actual);
		if (actual !== expected) begin
			$display("mismatch %s: expected %02h, actual %02h", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_reads(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic write_reg(input int reg_addr, input int reg_val);
		@(posedge CLK);
		#0.5;
		wr      = 1'b1;
		address = bg_reg_pkg::bg_reg_e'(reg_addr[3:0]);
		data_in = reg_val[15:0];
		@(posedge CLK);
		#0.5;
		wr = 1'b0;
	endtask

	task automatic pulse_h_tick();
		@(posedge CLK);
		#0.5;
		h_tick = 1'b1;
		@(posedge CLK);
		#0.5;
		h_tick = 1'b0;
	endtask

	// Color for a pixel shows two cycles after its display_x
	task automatic sweep_line(input int t);
		int total;
		total = LINE_PX + SWEEP_EXTRA;
		for (int i = 0; i < total + 2; i++) begin
			@(posedge CLK);
			#0.5;
			if (i >= 2 && i - 2 < LINE_PX)
				check_color($sformatf("line %0d pixel %0d", t, `BG_H_START + i - 2),
					exp_px[i-2], color_index);
			if (i < total) begin
				re        = 1'b1;
				display_x = `BG_X_W'(`BG_H_START + i);
			end else begin
				re = 1'b0;
			end
		end
	endtask

	// Memory model answers each request after 1 to 4 cycles
	always @(posedge CLK) begin
		#0.5;
		if (mem_rready) begin
			mem_rready = 1'b0;
		end else if (mem_rvalid === 1'b1) begin
			if (!busy) begin
				busy = 1'b1;
				take_bits(2, wait_left);
			end
			if (wait_left == 0) begin
				mem_data   = mem_img[mem_address];
				mem_rready = 1'b1;
				busy       = 1'b0;
				read_count++;
			end else begin
				wait_left--;
			end
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles, the line tests did not complete", cycles);
			stop_on_failure();
		end
	end

	initial begin
		int          n_blocks;
		int          blk_start;
		int          blk_count;
		int          n_tests;
		int          n_writes;
		int          reg_addr;
		int          reg_val;
		int          exp_reads;
		logic [15:0] line_y;
		logic [15:0] exp_word;
		RSTb       = 1'b0;
		wr         = 1'b0;
		address    = bg_reg_pkg::ctrl0;
		data_in    = '0;
		v_tick     = 1'b0;
		h_tick     = 1'b0;
		display_x  = '0;
		display_y  = '0;
		re         = 1'b0;
		mem_data   = '0;
		mem_rready = 1'b0;
		busy       = 1'b0;
		wait_left  = 0;
		lfsr       = 32'hb7d;
		vp         = 0;
		read_count = 0;
		for (int i = 0; i < 65536; i++)
			mem_img[i] = '0;
		$readmemh("testbench/bg_vectors.txt", vec);
		n_blocks = int'(pop_vector());
		for (int b = 0; b < n_blocks; b++) begin
			blk_start = int'(pop_vector());
			blk_count = int'(pop_vector());
			for (int k = 0; k < blk_count; k++)
				mem_img[blk_start + k] = pop_vector();
		end
		n_tests = int'(pop_vector());
		cycle_limit = RESET_CYCLES + n_tests * (2 * FETCH_BUDGET + LINE_PX + 64) + 200;

		repeat (RESET_CYCLES) @(posedge CLK);
		#0.5;
		RSTb = 1'b1;

		for (int t = 1; t <= n_tests; t++) begin
			n_writes = int'(pop_vector());
			for (int w = 0; w < n_writes; w++) begin
				reg_addr = int'(pop_vector());
				reg_val  = int'(pop_vector());
				write_reg(reg_addr, reg_val);
			end
			line_y    = pop_vector();
			exp_reads = int'(pop_vector());
			for (int p = 0; p < LINE_PX; p += 2) begin
				exp_word    = pop_vector();
				exp_px[p]   = exp_word[7:0];
				exp_px[p+1] = exp_word[15:8];
			end
			display_y  = line_y[`BG_X_W-1:0];
			read_count = 0;
			// Fetch into the fill pair and swap it to the display side
			pulse_h_tick();
			repeat (FETCH_BUDGET) @(posedge CLK);
			check_reads($sformatf("line %0d reads", t), exp_reads, read_count);
			pulse_h_tick();
			sweep_line(t);
			repeat (FETCH_BUDGET) @(posedge CLK);
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: testbench/bg_vectors.txt
// Memory: block count, then per block start address, word count, words
// Tests: count, then writes n, reg/value pairs, display_y, reads, 64 color pairs (low byte left)
0006
0004 000C 4321 4321 4321 4321 0505 0505 0505 0505 6666 6666 6666 6666
0044 0008 8765 8765 8765 8765 00A9 00A9 00A9 00A9
1000 0004 0201 0201 0201 0201
1040 0004 02FF 0201 0201 0201
1080 0005 0100 0102 0102 0102 0002
2000 0004 0303 0303 0303 0303
0005
// Both layers disabled
0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
// Layer 1 only, no scroll
0003 0000 0031 0003 1000 0004 0000 0000 0028
3231 3433 3231 3433 3231 3433 3231 3433 0035 0035 0035 0035 0035 0035 0035 0035
3231 3433 3231 3433 3231 3433 3231 3433 0035 0035 0035 0035 0035 0035 0035 0035
3231 3433 3231 3433 3231 3433 3231 3433 0035 0035 0035 0035 0035 0035 0035 0035
3231 3433 3231 3433 3231 3433 3231 3433 0035 0035 0035 0035 0035 0035 0035 0035
// Map row 1 starts with transparent tile 255
0000 0010 0024
0000 0000 0000 0000 0000 0000 0000 0000 0035 0035 0035 0035 0035 0035 0035 0035
3231 3433 3231 3433 3231 3433 3231 3433 0035 0035 0035 0035 0035 0035 0035 0035
3231 3433 3231 3433 3231 3433 3231 3433 0035 0035 0035 0035 0035 0035 0035 0035
3231 3433 3231 3433 3231 3433 3231 3433 0035 0035 0035 0035 0035 0035 0035 0035
// Two layers, layer 2 shows through the zero pixels
0003 0005 0071 0008 2000 0009 0000 0000 0050
3231 3433 3231 3433 3231 3433 3231 3433 7635 7635 7635 7635 7635 7635 7635 7635
3231 3433 3231 3433 3231 3433 3231 3433 7635 7635 7635 7635 7635 7635 7635 7635
3231 3433 3231 3433 3231 3433 3231 3433 7635 7635 7635 7635 7635 7635 7635 7635
3231 3433 3231 3433 3231 3433 3231 3433 7635 7635 7635 7635 7635 7635 7635 7635
// Layer 2 off, scroll x 0x15 and y 0x21
0003 0005 0070 0001 0015 0002 0021 0000 0028
3736 3538 3736 3538 3736 3938 703A 3970 703A 3970 703A 3970 703A 3570 3736 3538
3736 3538 3736 3538 3736 3938 703A 3970 703A 3970 703A 3970 703A 3570 3736 3538
3736 3538 3736 3538 3736 3938 703A 3970 703A 3970 703A 3970 703A 3570 3736 3538
3736 3538 3736 3538 3736 3938 703A 3970 703A 3970 703A 3970 703A 7070 7070 7070

// File: bg_renderer.f
+incdir+hw
hw/bg_reg_pkg.sv
hw/bg_fetch_pkg.sv
hw/bg_regs.sv
hw/scanline_bram.sv
hw/tile_fetcher.sv
hw/line_buffer_mixer.sv
hw/bg_renderer.sv
testbench/bg_renderer_properties.sv
testbench/tb_bg_renderer.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_bg_renderer -f bg_renderer.f
./obj_dir/Vtb_bg_renderer > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
	exit 1
fi
exit 0
